/* compile.f */
+incdir+include
hdl/i3c_target_pkg.sv
hdl/bus_monitor.sv
hdl/target_fsm.sv
hdl/byte_fifo.sv
hdl/target_csr.sv
hdl/i3c_target_top.sv
tests/tb_i3c_target.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP = tb_i3c_target
FILELIST = compile.f
BUILD_DIR = obj_dir
PASS_MSG = *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* tests/tb_i3c_target.sv */
// Directed testbench for the I3C target top level; compile with compile.f and run tb_i3c_target
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_cfg.svh"

module tb_i3c_target;

  localparam int CLK_PERIOD = 40;
  localparam int SCL_HALF = 10;
  localparam int IDLE_TIMEOUT = 50;

  // EVENTS bit weights
  localparam logic [31:0] EV_START = 32'h01;
  localparam logic [31:0] EV_STOP = 32'h02;
  localparam logic [31:0] EV_MATCH = 32'h04;
  localparam logic [31:0] EV_OVF = 32'h08;
  localparam logic [31:0] EV_NACK = 32'h10;
  localparam logic [31:0] EV_UNDER = 32'h20;

  logic clk;
  logic reset;
  logic scl_m;
  logic sda_m;
  logic sda_bus;
  logic sda_o;
  logic psel;
  logic penable;
  logic pwrite;
  logic [`I3C_APB_ADDR_W-1:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;
  logic irq;
  logic [31:0] rng_state;

  // Open-drain SDA, either side can pull low
  assign sda_bus = sda_m & sda_o;

  i3c_target_top dut (
    .clk_i(clk),
    .reset_i(reset),
    .scl_i(scl_m),
    .sda_i(sda_bus),
    .psel_i(psel),
    .penable_i(penable),
    .pwrite_i(pwrite),
    .paddr_i(paddr),
    .pwdata_i(pwdata),
    .sda_o(sda_o),
    .prdata_o(prdata),
    .pready_o(pready),
    .pslverr_o(pslverr),
    .irq_o(irq)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] t=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp));
    end
  endtask

  task automatic wait_clocks(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic random_byte(output logic [7:0] value);
    rng_state = xorshift32(rng_state);
    value = rng_state[7:0];
  endtask

  // One setup and one access cycle, called on a falling edge
  task automatic apb_access(input logic write, input logic [`I3C_APB_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(negedge clk);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    // No wait states, so the access cycle must complete at once
    check_value("pready_o", pready, 32'h1);
    rdata = prdata;
    err = pslverr;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic reg_write(input logic [`I3C_APB_ADDR_W-1:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic err;
    apb_access(1'b1, addr, data, rdata, err);
    check_value("pslverr_o", err, 32'h0);
  endtask

  task automatic reg_read_check(input string name, input logic [`I3C_APB_ADDR_W-1:0] addr,
                                input logic [31:0] exp);
    logic [31:0] rdata;
    logic err;
    apb_access(1'b0, addr, 32'h0, rdata, err);
    check_value("pslverr_o", err, 32'h0);
    check_value(name, rdata, exp);
  endtask

  // Poll STATUS until the STOP has cleared the busy flag
  task automatic wait_bus_free();
    logic [31:0] status;
    logic err;
    int polls;
    polls = 0;
    apb_access(1'b0, `I3C_REG_STATUS, 32'h0, status, err);
    while (status[16]) begin
      if (polls == IDLE_TIMEOUT) begin
        fail_run("Timeout waiting for the bus busy flag to clear after STOP");
      end
      apb_access(1'b0, `I3C_REG_STATUS, 32'h0, status, err);
      polls++;
    end
  endtask

  // One SCL clock, sampling SDA in the middle of the high phase
  task automatic clock_bit(output logic sampled);
    wait_clocks(SCL_HALF);
    scl_m = 1'b1;
    wait_clocks(SCL_HALF / 2);
    sampled = sda_bus;
    wait_clocks(SCL_HALF - SCL_HALF / 2);
    scl_m = 1'b0;
  endtask

  task automatic bus_start();
    scl_m = 1'b1;
    sda_m = 1'b1;
    wait_clocks(SCL_HALF);
    sda_m = 1'b0;
    wait_clocks(SCL_HALF);
    scl_m = 1'b0;
  endtask

  task automatic bus_stop();
    sda_m = 1'b0;
    wait_clocks(SCL_HALF);
    scl_m = 1'b1;
    wait_clocks(SCL_HALF);
    sda_m = 1'b1;
    wait_clocks(SCL_HALF);
    wait_bus_free();
  endtask

  task automatic write_byte(input logic [7:0] data, output logic ack);
    logic ignored;
    for (int i = 7; i >= 0; i--) begin
      sda_m = data[i];
      clock_bit(ignored);
    end
    sda_m = 1'b1;
    clock_bit(ack);
  endtask

  task automatic read_byte(input logic nack, output logic [7:0] data);
    logic bit_val;
    sda_m = 1'b1;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(bit_val);
      data[i] = bit_val;
    end
    sda_m = nack;
    clock_bit(bit_val);
  endtask

  task automatic send_address(input logic [6:0] addr, input logic rnw, output logic ack);
    bus_start();
    write_byte({addr, rnw}, ack);
  endtask

  task automatic test_reset_state();
    logic [31:0] rdata;
    logic err;
    check_value("sda_o", sda_o, 32'h1);
    check_value("irq_o", irq, 32'h0);
    check_value("pslverr_o", pslverr, 32'h0);
    reg_read_check("CTRL", `I3C_REG_CTRL, 32'h0);
    reg_read_check("ADDR", `I3C_REG_ADDR, 32'h22);
    reg_read_check("STATUS", `I3C_REG_STATUS, 32'h0);
    reg_read_check("EVENTS", `I3C_REG_EVENTS, 32'h0);
    apb_access(1'b0, 8'h18, 32'h0, rdata, err);
    check_value("pslverr_o unmapped read", err, 32'h1);
    apb_access(1'b1, `I3C_REG_STATUS, 32'hFFFF, rdata, err);
    check_value("pslverr_o STATUS write", err, 32'h1);
  endtask

  task automatic test_static_write();
    logic [7:0] data [3];
    logic ack;
    reg_write(`I3C_REG_CTRL, 32'h1);
    send_address(7'h22, 1'b0, ack);
    check_value("address ACK", ack, 32'h0);
    for (int i = 0; i < 3; i++) begin
      random_byte(data[i]);
      write_byte(data[i], ack);
      check_value("data ACK", ack, 32'h0);
    end
    // Bus still busy before the STOP
    reg_read_check("STATUS", `I3C_REG_STATUS, 32'h10003);
    bus_stop();
    reg_read_check("STATUS", `I3C_REG_STATUS, 32'h3);
    for (int i = 0; i < 3; i++) begin
      reg_read_check("RX_DATA", `I3C_REG_RX_DATA, {24'h0, data[i]});
    end
    reg_read_check("EVENTS", `I3C_REG_EVENTS, EV_START | EV_STOP | EV_MATCH);
    check_value("irq_o", irq, 32'h0);
    reg_write(`I3C_REG_CTRL, 32'h1 | (EV_NACK << 8));
    check_value("irq_o", irq, 32'h0);
    reg_write(`I3C_REG_CTRL, 32'h1 | (EV_MATCH << 8));
    check_value("irq_o", irq, 32'h1);
    reg_write(`I3C_REG_EVENTS, EV_START | EV_STOP | EV_MATCH);
    reg_read_check("EVENTS", `I3C_REG_EVENTS, 32'h0);
    check_value("irq_o", irq, 32'h0);
    reg_write(`I3C_REG_CTRL, 32'h1);
  endtask

  task automatic test_mismatch_disable();
    logic ack;
    send_address(7'h23, 1'b0, ack);
    check_value("wrong address ACK", ack, 32'h1);
    write_byte(8'h5A, ack);
    check_value("data ACK after mismatch", ack, 32'h1);
    bus_stop();
    reg_read_check("STATUS", `I3C_REG_STATUS, 32'h0);
    reg_read_check("EVENTS", `I3C_REG_EVENTS, EV_START | EV_STOP);
    reg_write(`I3C_REG_EVENTS, 32'h3F);
    reg_write(`I3C_REG_CTRL, 32'h0);
    send_address(7'h22, 1'b0, ack);
    check_value("disabled address ACK", ack, 32'h1);
    bus_stop();
    reg_read_check("EVENTS", `I3C_REG_EVENTS, EV_START | EV_STOP);
    reg_write(`I3C_REG_EVENTS, 32'h3F);
    reg_write(`I3C_REG_CTRL, 32'h1);
  endtask

  task automatic test_dynamic_address();
    logic [31:0] addr_word;
    logic [7:0] data;
    logic ack;
    // Dynamic 0x35 with valid set, static kept at 0x22
    addr_word = 32'h22 | (32'h35 << 8) | (32'h1 << 15);
    reg_write(`I3C_REG_ADDR, addr_word);
    reg_read_check("ADDR", `I3C_REG_ADDR, addr_word);
    random_byte(data);
    send_address(7'h35, 1'b0, ack);
    check_value("dynamic address ACK", ack, 32'h0);
    write_byte(data, ack);
    check_value("data ACK", ack, 32'h0);
    bus_stop();
    send_address(7'h22, 1'b0, ack);
    check_value("static address ACK", ack, 32'h1);
    bus_stop();
    reg_read_check("STATUS", `I3C_REG_STATUS, 32'h1);
    reg_read_check("RX_DATA", `I3C_REG_RX_DATA, {24'h0, data});
    reg_read_check("EVENTS", `I3C_REG_EVENTS, EV_START | EV_STOP | EV_MATCH);
    reg_write(`I3C_REG_EVENTS, 32'h3F);
    reg_write(`I3C_REG_ADDR, 32'h22);
  endtask

  task automatic test_read_transfer();
    logic [7:0] tx_bytes [2];
    logic [7:0] data;
    logic ack;
    random_byte(tx_bytes[0]);
    random_byte(tx_bytes[1]);
    reg_write(`I3C_REG_TX_DATA, {24'h0, tx_bytes[0]});
    reg_write(`I3C_REG_TX_DATA, {24'h0, tx_bytes[1]});
    reg_read_check("STATUS", `I3C_REG_STATUS, 32'h200);
    send_address(7'h22, 1'b1, ack);
    check_value("read address ACK", ack, 32'h0);
    read_byte(1'b0, data);
    check_value("read byte 0", data, {24'h0, tx_bytes[0]});
    read_byte(1'b1, data);
    check_value("read byte 1", data, {24'h0, tx_bytes[1]});
    bus_stop();
    reg_read_check("STATUS", `I3C_REG_STATUS, 32'h0);
    reg_read_check("EVENTS", `I3C_REG_EVENTS, EV_START | EV_STOP | EV_MATCH | EV_NACK);
    reg_write(`I3C_REG_EVENTS, 32'h3F);
    // Empty TX queue sends all ones
    send_address(7'h22, 1'b1, ack);
    check_value("read address ACK", ack, 32'h0);
    read_byte(1'b1, data);
    check_value("underrun byte", data, 32'hFF);
    bus_stop();
    reg_read_check("EVENTS", `I3C_REG_EVENTS,
                   EV_START | EV_STOP | EV_MATCH | EV_NACK | EV_UNDER);
    reg_write(`I3C_REG_EVENTS, 32'h3F);
  endtask

  task automatic test_rx_overflow();
    logic [7:0] data [`I3C_FIFO_DEPTH + 1];
    logic ack;
    send_address(7'h22, 1'b0, ack);
    check_value("address ACK", ack, 32'h0);
    for (int i = 0; i <= `I3C_FIFO_DEPTH; i++) begin
      random_byte(data[i]);
      write_byte(data[i], ack);
      check_value("data ACK", ack, (i == `I3C_FIFO_DEPTH) ? 32'h1 : 32'h0);
    end
    bus_stop();
    reg_read_check("EVENTS", `I3C_REG_EVENTS, EV_START | EV_STOP | EV_MATCH | EV_OVF);
    reg_read_check("STATUS", `I3C_REG_STATUS, 32'(`I3C_FIFO_DEPTH));
    for (int i = 0; i < `I3C_FIFO_DEPTH; i++) begin
      reg_read_check("RX_DATA", `I3C_REG_RX_DATA, {24'h0, data[i]});
    end
    reg_read_check("RX_DATA empty", `I3C_REG_RX_DATA, 32'h0);
    reg_read_check("STATUS", `I3C_REG_STATUS, 32'h0);
  endtask

  initial begin
    rng_state = 32'd37992;
    reset = 1'b1;
    scl_m = 1'b1;
    sda_m = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = 32'h0;
    wait_clocks(4);
    reset = 1'b0;
    wait_clocks(2);
    test_reset_state();
    test_static_write();
    test_mismatch_disable();
    test_dynamic_address();
    test_read_transfer();
    test_rx_overflow();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/i3c_target_top.sv */
// Top level of the I3C/I2C SDR target: bus monitor, FSM, RX/TX queues and APB registers
`timescale 1ns/1ps
`default_nettype none

module i3c_target_top
  import i3c_target_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      scl_i,
  input  logic      sda_i,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_addr_t paddr_i,
  input  reg_t      pwdata_i,
  output logic      sda_o,
  output reg_t      prdata_o,
  output logic      pready_o,
  output logic      pslverr_o,
  output logic      irq_o
);

  logic sda_s;
  logic bus_start;
  logic bus_stop;
  logic scl_rise;
  logic scl_fall;
  logic bus_busy;

  logic enable;
  addr7_t own_addr;

  logic rx_push;
  logic rx_pop;
  logic rx_full;
  byte_t rx_wdata;
  byte_t rx_rdata;
  level_t rx_level;

  logic tx_push;
  logic tx_pop;
  logic tx_empty;
  byte_t tx_wdata;
  byte_t tx_rdata;
  level_t tx_level;

  logic ev_addr_match;
  logic ev_rx_overflow;
  logic ev_host_nack;
  logic ev_tx_underrun;

  bus_monitor u_bus_monitor (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .scl_i(scl_i),
    .sda_i(sda_i),
    .scl_s_o(),
    .sda_s_o(sda_s),
    .start_o(bus_start),
    .stop_o(bus_stop),
    .scl_rise_o(scl_rise),
    .scl_fall_o(scl_fall),
    .busy_o(bus_busy)
  );

  target_fsm u_target_fsm (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .enable_i(enable),
    .own_addr_i(own_addr),
    .sda_s_i(sda_s),
    .start_i(bus_start),
    .stop_i(bus_stop),
    .scl_rise_i(scl_rise),
    .scl_fall_i(scl_fall),
    .sda_o(sda_o),
    .rx_full_i(rx_full),
    .rx_push_o(rx_push),
    .rx_data_o(rx_wdata),
    .tx_empty_i(tx_empty),
    .tx_data_i(tx_rdata),
    .tx_pop_o(tx_pop),
    .ev_addr_match_o(ev_addr_match),
    .ev_rx_overflow_o(ev_rx_overflow),
    .ev_host_nack_o(ev_host_nack),
    .ev_tx_underrun_o(ev_tx_underrun)
  );

  // Bus to host
  byte_fifo rx_fifo (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .push_i(rx_push),
    .push_data_i(rx_wdata),
    .pop_i(rx_pop),
    .pop_data_o(rx_rdata),
    .full_o(rx_full),
    .empty_o(),
    .level_o(rx_level)
  );

  // Host to bus
  byte_fifo tx_fifo (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .push_i(tx_push),
    .push_data_i(tx_wdata),
    .pop_i(tx_pop),
    .pop_data_o(tx_rdata),
    .full_o(),
    .empty_o(tx_empty),
    .level_o(tx_level)
  );

  target_csr u_target_csr (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .psel_i(psel_i),
    .penable_i(penable_i),
    .pwrite_i(pwrite_i),
    .paddr_i(paddr_i),
    .pwdata_i(pwdata_i),
    .prdata_o(prdata_o),
    .pready_o(pready_o),
    .pslverr_o(pslverr_o),
    .rx_level_i(rx_level),
    .tx_level_i(tx_level),
    .rx_data_i(rx_rdata),
    .busy_i(bus_busy),
    .ev_start_i(bus_start),
    .ev_stop_i(bus_stop),
    .ev_addr_match_i(ev_addr_match),
    .ev_rx_overflow_i(ev_rx_overflow),
    .ev_host_nack_i(ev_host_nack),
    .ev_tx_underrun_i(ev_tx_underrun),
    .enable_o(enable),
    .own_addr_o(own_addr),
    .rx_pop_o(rx_pop),
    .tx_push_o(tx_push),
    .tx_data_o(tx_wdata),
    .irq_o(irq_o)
  );

endmodule

`default_nettype wire

/* hdl/target_csr.sv */
// APB register block: control, addresses, status, W1C event flags and queue data windows
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_cfg.svh"

module target_csr
  import i3c_target_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_addr_t paddr_i,
  input  reg_t      pwdata_i,
  output reg_t      prdata_o,
  output logic      pready_o,
  output logic      pslverr_o,

  input  level_t    rx_level_i,
  input  level_t    tx_level_i,
  input  byte_t     rx_data_i,
  input  logic      busy_i,
  input  logic      ev_start_i,
  input  logic      ev_stop_i,
  input  logic      ev_addr_match_i,
  input  logic      ev_rx_overflow_i,
  input  logic      ev_host_nack_i,
  input  logic      ev_tx_underrun_i,

  output logic      enable_o,
  output addr7_t    own_addr_o,
  output logic      rx_pop_o,
  output logic      tx_push_o,
  output byte_t     tx_data_o,
  output logic      irq_o
);

  logic access;
  logic wr_en;
  logic rd_en;
  logic addr_mapped;
  logic addr_ro;
  logic ctrl_enable_q;
  logic [5:0] irq_mask_q;
  addr7_t static_addr_q;
  addr7_t dyn_addr_q;
  logic dyn_valid_q;
  logic [5:0] events_q;
  logic [5:0] ev_in;
  logic [5:0] ev_clear;
  reg_t rd_data;

  assign access = psel_i && penable_i;
  assign wr_en = access && pwrite_i;
  assign rd_en = access && !pwrite_i;

  // Read mux and offset decode
  always_comb begin
    rd_data = '0;
    addr_mapped = 1'b1;
    addr_ro = 1'b0;
    case (paddr_i)
      `I3C_REG_CTRL: begin
        rd_data[0] = ctrl_enable_q;
        rd_data[13:8] = irq_mask_q;
      end
      `I3C_REG_ADDR: begin
        rd_data[6:0] = static_addr_q;
        rd_data[14:8] = dyn_addr_q;
        rd_data[15] = dyn_valid_q;
      end
      `I3C_REG_STATUS: begin
        rd_data[`I3C_FIFO_LEVEL_W-1:0] = rx_level_i;
        rd_data[8 +: `I3C_FIFO_LEVEL_W] = tx_level_i;
        rd_data[16] = busy_i;
        addr_ro = 1'b1;
      end
      `I3C_REG_EVENTS: rd_data[5:0] = events_q;
      `I3C_REG_RX_DATA: begin
        // Empty queue reads as zero
        if (rx_level_i != '0) begin
          rd_data[7:0] = rx_data_i;
        end
        addr_ro = 1'b1;
      end
      `I3C_REG_TX_DATA: rd_data = '0;
      default: addr_mapped = 1'b0;
    endcase
  end

  assign prdata_o = rd_data;
  assign pready_o = 1'b1;
  assign pslverr_o = access && (!addr_mapped || (pwrite_i && addr_ro));

  assign rx_pop_o = rd_en && (paddr_i == `I3C_REG_RX_DATA) && (rx_level_i != '0);
  assign tx_push_o = wr_en && (paddr_i == `I3C_REG_TX_DATA);
  assign tx_data_o = pwdata_i[7:0];

  assign ev_in = {ev_tx_underrun_i, ev_host_nack_i, ev_rx_overflow_i,
                  ev_addr_match_i, ev_stop_i, ev_start_i};
  assign ev_clear = (wr_en && (paddr_i == `I3C_REG_EVENTS)) ? pwdata_i[5:0] : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_enable_q <= 1'b0;
      irq_mask_q <= '0;
      static_addr_q <= `I3C_RST_STATIC_ADDR;
      dyn_addr_q <= '0;
      dyn_valid_q <= 1'b0;
      events_q <= '0;
    end else begin
      if (wr_en && (paddr_i == `I3C_REG_CTRL)) begin
        ctrl_enable_q <= pwdata_i[0];
        irq_mask_q <= pwdata_i[13:8];
      end
      if (wr_en && (paddr_i == `I3C_REG_ADDR)) begin
        static_addr_q <= pwdata_i[6:0];
        dyn_addr_q <= pwdata_i[14:8];
        dyn_valid_q <= pwdata_i[15];
      end
      // A new event wins over a clear of the same bit
      events_q <= (events_q & ~ev_clear) | ev_in;
    end
  end

  assign enable_o = ctrl_enable_q;
  assign own_addr_o = dyn_valid_q ? dyn_addr_q : static_addr_q;
  assign irq_o = |(events_q & irq_mask_q);

endmodule

`default_nettype wire

/* hdl/byte_fifo.sv */
// First-word-fall-through byte queue with fill level, used for the RX and TX paths
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_cfg.svh"

module byte_fifo
  import i3c_target_pkg::*;
#(
  parameter int unsigned DEPTH = `I3C_FIFO_DEPTH
) (
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   push_i,
  input  byte_t  push_data_i,
  input  logic   pop_i,
  output byte_t  pop_data_o,
  output logic   full_o,
  output logic   empty_o,
  output level_t level_o
);

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  byte_t mem_q [DEPTH];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  level_t level_q;
  logic do_push;
  logic do_pop;

  assign full_o = (level_q == level_t'(DEPTH));
  assign empty_o = (level_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q <= '0;
    end else begin
      // Pointers wrap on their own for a power-of-two depth
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        level_q <= level_q + 1'b1;
      end else if (do_pop && !do_push) begin
        level_q <= level_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  assign pop_data_o = mem_q[rd_ptr_q];
  assign level_o = level_q;

endmodule

`default_nettype wire

/* hdl/target_fsm.sv */
// Target-side bus state machine: address match, ACK/NACK, byte shifting and event pulses
`timescale 1ns/1ps
`default_nettype none

module target_fsm
  import i3c_target_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   enable_i,
  input  addr7_t own_addr_i,
  input  logic   sda_s_i,
  input  logic   start_i,
  input  logic   stop_i,
  input  logic   scl_rise_i,
  input  logic   scl_fall_i,
  output logic   sda_o,

  input  logic   rx_full_i,
  output logic   rx_push_o,
  output byte_t  rx_data_o,

  input  logic   tx_empty_i,
  input  byte_t  tx_data_i,
  output logic   tx_pop_o,

  output logic   ev_addr_match_o,
  output logic   ev_rx_overflow_o,
  output logic   ev_host_nack_o,
  output logic   ev_tx_underrun_o
);

  target_state_e state_q;
  logic [2:0] bit_cnt_q;
  byte_t shift_q;
  byte_t tx_byte;
  logic rnw_q;
  logic ack_phase_q;
  logic nack_q;
  logic addr_hit;

  // Address bits sit in shift_q[6:0] when the RnW bit is sampled
  assign addr_hit = enable_i && (shift_q[6:0] == own_addr_i);

  // Empty queue sends all ones
  assign tx_byte = tx_empty_i ? 8'hFF : tx_data_i;

  assign rx_data_o = shift_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      bit_cnt_q <= '0;
      shift_q <= '0;
      rnw_q <= 1'b0;
      ack_phase_q <= 1'b0;
      nack_q <= 1'b0;
      sda_o <= 1'b1;
      rx_push_o <= 1'b0;
      tx_pop_o <= 1'b0;
      ev_addr_match_o <= 1'b0;
      ev_rx_overflow_o <= 1'b0;
      ev_host_nack_o <= 1'b0;
      ev_tx_underrun_o <= 1'b0;
    end else begin
      rx_push_o <= 1'b0;
      tx_pop_o <= 1'b0;
      ev_addr_match_o <= 1'b0;
      ev_rx_overflow_o <= 1'b0;
      ev_host_nack_o <= 1'b0;
      ev_tx_underrun_o <= 1'b0;

      if (start_i) begin
        // Also a repeated START, abort and take a new address
        state_q <= ADDR;
        bit_cnt_q <= '0;
        ack_phase_q <= 1'b0;
        sda_o <= 1'b1;
      end else if (stop_i) begin
        state_q <= IDLE;
        ack_phase_q <= 1'b0;
        sda_o <= 1'b1;
      end else begin
        case (state_q)
          ADDR: begin
            if (scl_rise_i) begin
              shift_q <= {shift_q[6:0], sda_s_i};
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (bit_cnt_q == 3'd7) begin
                rnw_q <= sda_s_i;
                if (addr_hit) begin
                  state_q <= ADDR_ACK;
                  ev_addr_match_o <= 1'b1;
                end else begin
                  state_q <= WAIT_STOP;
                end
              end
            end
          end

          ADDR_ACK: begin
            if (scl_fall_i) begin
              if (!ack_phase_q) begin
                sda_o <= 1'b0;
                ack_phase_q <= 1'b1;
              end else begin
                ack_phase_q <= 1'b0;
                if (rnw_q) begin
                  // First read bit goes out as the ACK clock ends
                  state_q <= RD_DATA;
                  shift_q <= tx_byte;
                  sda_o <= tx_byte[7];
                  tx_pop_o <= !tx_empty_i;
                  ev_tx_underrun_o <= tx_empty_i;
                end else begin
                  state_q <= WR_DATA;
                  sda_o <= 1'b1;
                end
              end
            end
          end

          WR_DATA: begin
            if (scl_rise_i) begin
              shift_q <= {shift_q[6:0], sda_s_i};
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (bit_cnt_q == 3'd7) begin
                state_q <= WR_ACK;
                nack_q <= rx_full_i;
                rx_push_o <= !rx_full_i;
                ev_rx_overflow_o <= rx_full_i;
              end
            end
          end

          WR_ACK: begin
            if (scl_fall_i) begin
              if (!ack_phase_q) begin
                sda_o <= nack_q;
                ack_phase_q <= 1'b1;
              end else begin
                ack_phase_q <= 1'b0;
                sda_o <= 1'b1;
                state_q <= nack_q ? WAIT_STOP : WR_DATA;
              end
            end
          end

          RD_DATA: begin
            if (scl_fall_i) begin
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (bit_cnt_q == 3'd7) begin
                // Release for the master's ACK bit
                sda_o <= 1'b1;
                state_q <= RD_ACK;
              end else begin
                shift_q <= {shift_q[6:0], 1'b1};
                sda_o <= shift_q[6];
              end
            end
          end

          RD_ACK: begin
            if (scl_rise_i && !ack_phase_q) begin
              if (sda_s_i) begin
                ev_host_nack_o <= 1'b1;
                state_q <= WAIT_STOP;
              end else begin
                ack_phase_q <= 1'b1;
              end
            end else if (scl_fall_i && ack_phase_q) begin
              ack_phase_q <= 1'b0;
              state_q <= RD_DATA;
              shift_q <= tx_byte;
              sda_o <= tx_byte[7];
              tx_pop_o <= !tx_empty_i;
              ev_tx_underrun_o <= tx_empty_i;
            end
          end

          default: begin
            // IDLE and WAIT_STOP only leave on START or STOP
            sda_o <= 1'b1;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/bus_monitor.sv */
// Synchronizes SCL/SDA and decodes START, STOP and SCL edges for the target FSM
`timescale 1ns/1ps
`default_nettype none

module bus_monitor (
  input  logic clk_i,
  input  logic reset_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_s_o,
  output logic sda_s_o,
  output logic start_o,
  output logic stop_o,
  output logic scl_rise_o,
  output logic scl_fall_o,
  output logic busy_o
);

  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;
  logic scl_q;
  logic sda_q;
  logic start_d;
  logic stop_d;

  // Compare the synchronized level against the delayed copy
  assign start_d = scl_sync_q[1] && scl_q && sda_q && !sda_sync_q[1];
  assign stop_d = scl_sync_q[1] && scl_q && !sda_q && sda_sync_q[1];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // Idle bus has both lines high
      scl_sync_q <= 2'b11;
      sda_sync_q <= 2'b11;
      scl_q <= 1'b1;
      sda_q <= 1'b1;
      start_o <= 1'b0;
      stop_o <= 1'b0;
      scl_rise_o <= 1'b0;
      scl_fall_o <= 1'b0;
      busy_o <= 1'b0;
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_i};
      sda_sync_q <= {sda_sync_q[0], sda_i};
      scl_q <= scl_sync_q[1];
      sda_q <= sda_sync_q[1];
      start_o <= start_d;
      stop_o <= stop_d;
      scl_rise_o <= scl_sync_q[1] && !scl_q;
      scl_fall_o <= !scl_sync_q[1] && scl_q;
      if (start_d) begin
        busy_o <= 1'b1;
      end else if (stop_d) begin
        busy_o <= 1'b0;
      end
    end
  end

  // Delayed levels line up with the registered pulses
  assign scl_s_o = scl_q;
  assign sda_s_o = sda_q;

endmodule

`default_nettype wire

/* hdl/i3c_target_pkg.sv */
// Shared vector types and the target state encoding, imported by the I3C target RTL
`default_nettype none

`include "i3c_target_cfg.svh"

package i3c_target_pkg;

  // One data byte on the bus
  typedef logic [7:0] byte_t;

  // 7-bit bus address without the RnW bit
  typedef logic [6:0] addr7_t;

  // Queue fill level
  typedef logic [`I3C_FIFO_LEVEL_W-1:0] level_t;

  typedef logic [`I3C_APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [31:0] reg_t;

  typedef enum logic [2:0] {
    IDLE,
    ADDR,
    ADDR_ACK,
    WR_DATA,
    WR_ACK,
    RD_DATA,
    RD_ACK,
    WAIT_STOP
  } target_state_e;

endpackage

`default_nettype wire

/* include/i3c_target_cfg.svh */
// Build-time sizes, register offsets and reset values for the I3C target; include where needed
`ifndef I3C_TARGET_CFG_SVH
`define I3C_TARGET_CFG_SVH

// Byte queue sizing, level counts 0 to depth
`define I3C_FIFO_DEPTH 8
`define I3C_FIFO_LEVEL_W 4

// Host bus
`define I3C_APB_ADDR_W 8

// Static address after reset
`define I3C_RST_STATIC_ADDR 7'h22

// Register offsets
`define I3C_REG_CTRL 8'h00
`define I3C_REG_ADDR 8'h04
`define I3C_REG_STATUS 8'h08
`define I3C_REG_EVENTS 8'h0C
`define I3C_REG_RX_DATA 8'h10
`define I3C_REG_TX_DATA 8'h14

`endif
